// File: host_chan_pkg.sv
// Shared sizes, opcodes and bundles for the single-port host channel shim
// MMIO buffer depth must stay a power of two so the pointers wrap naturally
// Host memory data is kept at 64 bits to keep simulation light

package host_chan_pkg;

    // ====================
    // Sizes
    // ====================

    localparam int MMIO_ADDR_W     = 16;
    localparam int MMIO_DATA_W     = 64;
    localparam int MMIO_TID_W      = 9;
    localparam int MEM_TAG_W       = 8;
    localparam int MEM_ADDR_W      = 64;
    localparam int MEM_DATA_W      = 64;
    localparam int MMIO_FIFO_DEPTH = 16;
    localparam int MMIO_FIFO_PTR_W = $clog2(MMIO_FIFO_DEPTH);
    localparam int CNT_W           = 32;

    // Avalon side addresses 64-bit words, so drop the byte offset
    localparam int AVMM_ADDR_W     = MMIO_ADDR_W - 3;

    typedef logic [MMIO_FIFO_PTR_W-1:0] t_fifo_ptr;
    // One extra bit so a full buffer is distinct from an empty one
    typedef logic [MMIO_FIFO_PTR_W:0]   t_fifo_cnt;
    typedef logic [CNT_W-1:0]           t_cnt;

    // ====================
    // Opcodes and states
    // ====================

    typedef enum logic [1:0] {
        RX_NONE,
        RX_MMIO_RD,
        RX_MMIO_WR,
        RX_MEM_RD_RSP
    } t_rx_op;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_CMD,
        MS_WAIT_DATA
    } t_mmio_state;

    // ====================
    // Bundles
    // ====================

    // Memory completion tag rides in the low bits of tid
    typedef struct packed {
        t_rx_op                  op;
        logic [MMIO_TID_W-1:0]   tid;
        logic [MMIO_ADDR_W-1:0]  addr;
        logic [MMIO_DATA_W-1:0]  data;
    } t_host_rx;

    typedef struct packed {
        logic                    is_write;
        logic [MMIO_TID_W-1:0]   tid;
        logic [MMIO_ADDR_W-1:0]  addr;
        logic [MMIO_DATA_W-1:0]  data;
    } t_mmio_req;

    typedef struct packed {
        logic                    valid;
        logic [MMIO_TID_W-1:0]   tid;
        logic [MMIO_DATA_W-1:0]  data;
    } t_mmio_rsp;

    typedef struct packed {
        logic                    valid;
        logic [MEM_TAG_W-1:0]    tag;
        logic [MEM_ADDR_W-1:0]   addr;
    } t_mem_rd_req;

    typedef struct packed {
        logic                    valid;
        logic [MEM_TAG_W-1:0]    tag;
        logic [MEM_DATA_W-1:0]   data;
    } t_mem_rd_rsp;

    // Word address; read and write are mutually exclusive
    typedef struct packed {
        logic                    read;
        logic                    write;
        logic [AVMM_ADDR_W-1:0]  address;
        logic [MMIO_DATA_W-1:0]  writedata;
    } t_avmm_cmd;

endpackage

// File: host_chan_rx_split.sv
// Host receive stream is registered once, fixed latency of one cycle
// No back-pressure toward the host, every beat is forwarded
// Overflow of the MMIO buffer is the host's responsibility

`timescale 1ns/1ps

module host_chan_rx_split
(
    input  logic                      clk,
    input  logic                      rst,
    input  host_chan_pkg::t_host_rx   host_rx,
    output logic                      fifo_push,
    output host_chan_pkg::t_mmio_req  fifo_din,
    output host_chan_pkg::t_mem_rd_rsp mem_rd_rsp
);

    // Opcode is control state and gets a reset
    host_chan_pkg::t_rx_op                   rx_op;

    // Payload flops, no reset needed
    logic [host_chan_pkg::MMIO_TID_W-1:0]    rx_tid;
    logic [host_chan_pkg::MMIO_ADDR_W-1:0]   rx_addr;
    logic [host_chan_pkg::MMIO_DATA_W-1:0]   rx_data;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rx_op <= host_chan_pkg::RX_NONE;
        end
        else
        begin
            rx_op <= host_rx.op;
        end
    end

    always_ff @(posedge clk)
    begin
        rx_tid  <= host_rx.tid;
        rx_addr <= host_rx.addr;
        rx_data <= host_rx.data;
    end

    // ====================
    // Route by opcode
    // ====================

    // MMIO reads and writes go to the buffer
    assign fifo_push = (rx_op == host_chan_pkg::RX_MMIO_RD) ||
                       (rx_op == host_chan_pkg::RX_MMIO_WR);

    always_comb
    begin
        fifo_din.is_write = (rx_op == host_chan_pkg::RX_MMIO_WR);
        fifo_din.tid      = rx_tid;
        fifo_din.addr     = rx_addr;
        fifo_din.data     = rx_data;
    end

    // Memory completions bypass the buffer entirely
    always_comb
    begin
        mem_rd_rsp.valid = (rx_op == host_chan_pkg::RX_MEM_RD_RSP);
        // Tag is the low part of tid
        mem_rd_rsp.tag   = rx_tid[host_chan_pkg::MEM_TAG_W-1:0];
        mem_rd_rsp.data  = rx_data;
    end

endmodule

// File: mmio_req_fifo.sv
// In-order buffer for MMIO requests, depth taken from the package
// Never drops a push, the host must not exceed the depth
// Head entry is shown combinationally, pop on an empty buffer is ignored

`timescale 1ns/1ps

module mmio_req_fifo
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      push,
    input  host_chan_pkg::t_mmio_req  din,
    input  logic                      pop,
    output host_chan_pkg::t_mmio_req  dout,
    output logic                      empty
);

    // Entry storage, no reset
    host_chan_pkg::t_mmio_req   mem [host_chan_pkg::MMIO_FIFO_DEPTH];

    host_chan_pkg::t_fifo_ptr   wr_ptr;
    host_chan_pkg::t_fifo_ptr   rd_ptr;
    host_chan_pkg::t_fifo_cnt   count;

    logic do_pop;

    // Only pop when something is there
    assign do_pop = pop && !empty;

    // ====================
    // Storage write
    // ====================

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= din;
        end
    end

    // ====================
    // Pointers and count
    // ====================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + host_chan_pkg::t_fifo_ptr'(1);
            end

            if (do_pop)
            begin
                rd_ptr <= rd_ptr + host_chan_pkg::t_fifo_ptr'(1);
            end

            // Simultaneous push and pop leaves the count alone
            if (push && !do_pop)
            begin
                count <= count + host_chan_pkg::t_fifo_cnt'(1);
            end
            else if (do_pop && !push)
            begin
                count <= count - host_chan_pkg::t_fifo_cnt'(1);
            end
        end
    end

    // Head straight from storage
    assign dout  = mem[rd_ptr];
    assign empty = (count == '0);

endmodule

// File: mmio_to_avalon.sv
// Replays buffered MMIO requests onto a 64-bit Avalon-MM master
// Only one read in flight, the next request waits for its response
// Low three byte-address bits are dropped, accesses are whole words

`timescale 1ns/1ps

module mmio_to_avalon
(
    input  logic                                   clk,
    input  logic                                   rst,
    input  host_chan_pkg::t_mmio_req               fifo_dout,
    input  logic                                   fifo_empty,
    output logic                                   fifo_pop,
    output host_chan_pkg::t_avmm_cmd               avmm_cmd,
    input  logic                                   avmm_waitrequest,
    input  logic                                   avmm_readdatavalid,
    input  logic [host_chan_pkg::MMIO_DATA_W-1:0]  avmm_readdata,
    output host_chan_pkg::t_mmio_rsp               mmio_rsp
);

    host_chan_pkg::t_mmio_state state;

    // Command strobes and response valid
    logic cmd_rd;
    logic cmd_wr;
    logic rsp_valid;

    // Payload of the active request
    logic [host_chan_pkg::AVMM_ADDR_W-1:0]  cmd_addr;
    logic [host_chan_pkg::MMIO_DATA_W-1:0]  cmd_wdata;
    logic [host_chan_pkg::MMIO_TID_W-1:0]   cmd_tid;
    logic [host_chan_pkg::MMIO_DATA_W-1:0]  rsp_data;

    logic load_req;

    // Take the head when idle and the buffer has something
    assign load_req = (state == host_chan_pkg::MS_IDLE) && !fifo_empty;

    // Head leaves the buffer in the acceptance cycle
    assign fifo_pop = (state == host_chan_pkg::MS_CMD) && !avmm_waitrequest;

    // ====================
    // FSM
    // ====================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= host_chan_pkg::MS_IDLE;
            cmd_rd    <= 1'b0;
            cmd_wr    <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            // Response is a single-cycle pulse
            rsp_valid <= 1'b0;

            case (state)
                host_chan_pkg::MS_IDLE:
                begin
                    if (load_req)
                    begin
                        cmd_rd <= !fifo_dout.is_write;
                        cmd_wr <= fifo_dout.is_write;
                        state  <= host_chan_pkg::MS_CMD;
                    end
                end

                host_chan_pkg::MS_CMD:
                begin
                    // Hold everything until waitrequest drops
                    if (!avmm_waitrequest)
                    begin
                        cmd_rd <= 1'b0;
                        cmd_wr <= 1'b0;
                        state  <= cmd_wr ? host_chan_pkg::MS_IDLE
                                         : host_chan_pkg::MS_WAIT_DATA;
                    end
                end

                host_chan_pkg::MS_WAIT_DATA:
                begin
                    if (avmm_readdatavalid)
                    begin
                        rsp_valid <= 1'b1;
                        state     <= host_chan_pkg::MS_IDLE;
                    end
                end

                default:
                begin
                    state <= host_chan_pkg::MS_IDLE;
                end
            endcase
        end
    end

    // ====================
    // Payload capture
    // ====================

    always_ff @(posedge clk)
    begin
        if (load_req)
        begin
            // Byte address to word address
            cmd_addr  <= fifo_dout.addr[host_chan_pkg::MMIO_ADDR_W-1:3];
            cmd_wdata <= fifo_dout.data;
            cmd_tid   <= fifo_dout.tid;
        end

        if ((state == host_chan_pkg::MS_WAIT_DATA) && avmm_readdatavalid)
        begin
            rsp_data <= avmm_readdata;
        end
    end

    always_comb
    begin
        avmm_cmd.read      = cmd_rd;
        avmm_cmd.write     = cmd_wr;
        avmm_cmd.address   = cmd_addr;
        avmm_cmd.writedata = cmd_wdata;

        // tid is still that of the read, next load comes later
        mmio_rsp.valid     = rsp_valid;
        mmio_rsp.tid       = cmd_tid;
        mmio_rsp.data      = rsp_data;
    end

endmodule

// File: host_chan_events.sv
// Counts host memory reads and their summed latency in cycles
// Mean latency is latency_sum divided by num_reads
// Counters wrap silently at CNT_W bits

`timescale 1ns/1ps

module host_chan_events
(
    input  logic                              clk,
    input  logic                              rst,
    input  host_chan_pkg::t_mem_rd_req        mem_rd_req,
    input  host_chan_pkg::t_mem_rd_rsp        mem_rd_rsp,
    output logic [host_chan_pkg::CNT_W-1:0]   num_reads,
    output logic [host_chan_pkg::CNT_W-1:0]   num_outstanding,
    output logic [host_chan_pkg::CNT_W-1:0]   latency_sum
);

    // ====================
    // Counters
    // ====================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            num_reads       <= '0;
            num_outstanding <= '0;
            latency_sum     <= '0;
        end
        else
        begin
            // Every issued read
            num_reads <= num_reads + host_chan_pkg::t_cnt'(mem_rd_req.valid);

            // Issue and completion in the same cycle cancel out
            if (mem_rd_req.valid && !mem_rd_rsp.valid)
            begin
                num_outstanding <= num_outstanding + host_chan_pkg::t_cnt'(1);
            end
            else if (!mem_rd_req.valid && mem_rd_rsp.valid)
            begin
                num_outstanding <= num_outstanding - host_chan_pkg::t_cnt'(1);
            end

            // Each cycle adds one per read still in flight
            latency_sum <= latency_sum + num_outstanding;
        end
    end

endmodule

// File: host_chan_shim.sv
// Single-port host channel shim, memory completions pass in one cycle
// MMIO goes through a buffer and out on Avalon-MM, one read at a time
// Host must keep outstanding MMIO requests within the buffer depth

`timescale 1ns/1ps

module host_chan_shim
(
    input  logic                                   clk,
    input  logic                                   rst,

    // Host side
    input  host_chan_pkg::t_host_rx                host_rx,
    output host_chan_pkg::t_mem_rd_req             host_tx_mem,
    output host_chan_pkg::t_mmio_rsp               mmio_rsp,

    // Accelerator memory path
    input  host_chan_pkg::t_mem_rd_req             mem_rd_req,
    output host_chan_pkg::t_mem_rd_rsp             mem_rd_rsp,

    // Accelerator register file on Avalon
    output host_chan_pkg::t_avmm_cmd               avmm_cmd,
    input  logic                                   avmm_waitrequest,
    input  logic                                   avmm_readdatavalid,
    input  logic [host_chan_pkg::MMIO_DATA_W-1:0]  avmm_readdata,

    // Event counters
    output logic [host_chan_pkg::CNT_W-1:0]        num_reads,
    output logic [host_chan_pkg::CNT_W-1:0]        num_outstanding,
    output logic [host_chan_pkg::CNT_W-1:0]        latency_sum
);

    logic                      fifo_push;
    host_chan_pkg::t_mmio_req  fifo_din;
    logic                      fifo_pop;
    host_chan_pkg::t_mmio_req  fifo_dout;
    logic                      fifo_empty;

    // Accelerator reads go to the host untouched
    assign host_tx_mem = mem_rd_req;

    // ====================
    // MMIO and memory split
    // ====================

    host_chan_rx_split rx_split
    (
        .clk        (clk),
        .rst        (rst),
        .host_rx    (host_rx),
        .fifo_push  (fifo_push),
        .fifo_din   (fifo_din),
        .mem_rd_rsp (mem_rd_rsp)
    );

    mmio_req_fifo mmio_fifo
    (
        .clk   (clk),
        .rst   (rst),
        .push  (fifo_push),
        .din   (fifo_din),
        .pop   (fifo_pop),
        .dout  (fifo_dout),
        .empty (fifo_empty)
    );

    // ====================
    // Avalon and events
    // ====================

    mmio_to_avalon av_mmio
    (
        .clk                (clk),
        .rst                (rst),
        .fifo_dout          (fifo_dout),
        .fifo_empty         (fifo_empty),
        .fifo_pop           (fifo_pop),
        .avmm_cmd           (avmm_cmd),
        .avmm_waitrequest   (avmm_waitrequest),
        .avmm_readdatavalid (avmm_readdatavalid),
        .avmm_readdata      (avmm_readdata),
        .mmio_rsp           (mmio_rsp)
    );

    // Watches the accelerator side of the memory path
    host_chan_events ev
    (
        .clk             (clk),
        .rst             (rst),
        .mem_rd_req      (mem_rd_req),
        .mem_rd_rsp      (mem_rd_rsp),
        .num_reads       (num_reads),
        .num_outstanding (num_outstanding),
        .latency_sum     (latency_sum)
    );

endmodule

// File: host_chan_checker.sv
// Avalon protocol and MMIO response assertions on the shim top level
// Bound to every host_chan_shim instance

`timescale 1ns/1ps

module host_chan_checker
(
    input logic                      clk,
    input logic                      rst,
    input host_chan_pkg::t_avmm_cmd  avmm_cmd,
    input logic                      avmm_waitrequest,
    input host_chan_pkg::t_mmio_rsp  mmio_rsp
);

    // Reads accepted on Avalon and not yet answered to the host
    int rd_inflight;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_inflight <= 0;
        end
        else
        begin
            rd_inflight <= rd_inflight + int'(avmm_cmd.read && !avmm_waitrequest)
                                       - int'(mmio_rsp.valid);
        end
    end

    // ====================
    // Properties
    // ====================

    cmd_stable: assert property (@(posedge clk) disable iff (rst)
        (avmm_cmd.read || avmm_cmd.write) && avmm_waitrequest |=> $stable(avmm_cmd))
    else $error("Avalon command changed under waitrequest");

    rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(avmm_cmd.read && avmm_cmd.write))
    else $error("Avalon read and write high together");

    rsp_in_flight: assert property (@(posedge clk) disable iff (rst)
        mmio_rsp.valid |-> rd_inflight > 0)
    else $error("MMIO read response without a read in flight");

endmodule

bind host_chan_shim host_chan_checker checker_i
(
    .clk              (clk),
    .rst              (rst),
    .avmm_cmd         (avmm_cmd),
    .avmm_waitrequest (avmm_waitrequest),
    .mmio_rsp         (mmio_rsp)
);

// File: tb_host_chan_shim.sv
// Testbench for the single-port host channel shim, one seeded random run
// Host side respects the MMIO buffer depth rule, no back-pressure is modeled
// Avalon slave holds 64 words indexed by the low word-address bits

`timescale 1ns/1ps

module tb_host_chan_shim;

    localparam int TEST_BEATS = 250;
    localparam int MMIO_LIM   = host_chan_pkg::MMIO_FIFO_DEPTH - 2;

    logic clk;
    logic rst;
    host_chan_pkg::t_host_rx     host_rx;
    host_chan_pkg::t_mem_rd_req  mem_rd_req;
    host_chan_pkg::t_mem_rd_req  host_tx_mem;
    host_chan_pkg::t_mem_rd_rsp  mem_rd_rsp;
    host_chan_pkg::t_mmio_rsp    mmio_rsp;
    host_chan_pkg::t_avmm_cmd    avmm_cmd;
    logic                        avmm_waitrequest;
    logic                        avmm_readdatavalid;
    logic [63:0]                 avmm_readdata;
    logic [31:0]                 num_reads;
    logic [31:0]                 num_outstanding;
    logic [31:0]                 latency_sum;

    // Reference model state
    integer seed;
    int     errors;
    int     cyc;
    int     wait_pct;
    int     mmio_sent;
    int     cmd_accepted;
    int     reads_issued;
    int     model_lat;
    logic [63:0] regs [64];
    logic [63:0] shadow [64];
    host_chan_pkg::t_avmm_cmd    exp_cmd [$];
    host_chan_pkg::t_mmio_rsp    exp_rsp [$];
    host_chan_pkg::t_mem_rd_rsp  exp_mem [$];
    int                          exp_cyc [$];
    logic [63:0]                 rd_data_q [$];
    int                          rd_due_q [$];
    logic [7:0]                  pend_tags [$];
    int                          pend_cyc [$];

    host_chan_shim host_chan_shim_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    function automatic void push_mem_expect(input host_chan_pkg::t_host_rx b);
        host_chan_pkg::t_mem_rd_rsp m;
        m.valid = 1'b1;
        m.tag   = b.tid[7:0];
        m.data  = b.data;
        exp_mem.push_back(m);
        // Driven at this edge, seen by the monitor two edges on
        exp_cyc.push_back(cyc + 2);
    endfunction

    // ====================
    // Host beat driver
    // ====================

    task automatic send_beat(input host_chan_pkg::t_rx_op op);
        host_chan_pkg::t_host_rx  b;
        host_chan_pkg::t_avmm_cmd c;
        host_chan_pkg::t_mmio_rsp r;
        int                       issued_at;
        b.op   = op;
        b.tid  = 9'($random(seed));
        b.addr = 16'($random(seed));
        b.data = {$random(seed), $random(seed)};
        @(posedge clk);
        // Host rule keeps the buffer from filling
        while (op != host_chan_pkg::RX_MEM_RD_RSP && (mmio_sent - cmd_accepted) >= MMIO_LIM)
        begin
            host_rx.op <= host_chan_pkg::RX_NONE;
            @(posedge clk);
        end
        if (op == host_chan_pkg::RX_MEM_RD_RSP)
        begin
            // Accelerator read first so the counters stay balanced
            mem_rd_req.valid <= 1'b1;
            mem_rd_req.tag   <= b.tid[7:0];
            mem_rd_req.addr  <= {$random(seed), $random(seed)};
            host_rx.op       <= host_chan_pkg::RX_NONE;
            reads_issued++;
            issued_at = cyc;
            @(posedge clk);
            mem_rd_req.valid <= 1'b0;
            push_mem_expect(b);
            // Read latency runs to the completion, one cycle behind the host beat
            model_lat += cyc + 1 - issued_at;
        end
        else
        begin
            c.read      = (op == host_chan_pkg::RX_MMIO_RD);
            c.write     = (op == host_chan_pkg::RX_MMIO_WR);
            c.address   = 13'(b.addr >> 3);
            c.writedata = c.write ? b.data : '0;
            if (c.write)
            begin
                shadow[b.addr[8:3]] = b.data;
            end
            else
            begin
                r.valid = 1'b1;
                r.tid   = b.tid;
                r.data  = shadow[b.addr[8:3]];
                exp_rsp.push_back(r);
            end
            exp_cmd.push_back(c);
            mmio_sent++;
        end
        host_rx <= b;
    endtask

    task automatic drain();
        @(posedge clk);
        host_rx.op       <= host_chan_pkg::RX_NONE;
        mem_rd_req.valid <= 1'b0;
        while (exp_cmd.size() != 0 || exp_rsp.size() != 0 || exp_mem.size() != 0)
        begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int err_before);
        $display("test %-12s %s (%0d errors)", name,
                 (errors == err_before) ? "ok" : "failed", errors - err_before);
    endtask

    // ====================
    // Avalon slave model
    // ====================

    always @(posedge clk)
    begin
        host_chan_pkg::t_avmm_cmd c;
        cyc <= cyc + 1;
        avmm_waitrequest   <= ({$random(seed)} % 100) < wait_pct;
        avmm_readdatavalid <= 1'b0;
        if (!rst && (avmm_cmd.read || avmm_cmd.write) && !avmm_waitrequest)
        begin
            cmd_accepted <= cmd_accepted + 1;
            assert (exp_cmd.size() != 0)
            else report_error("Avalon command with none expected");
            if (exp_cmd.size() != 0)
            begin
                c = exp_cmd.pop_front();
                assert (avmm_cmd.read == c.read && avmm_cmd.write == c.write &&
                        avmm_cmd.address == c.address &&
                        (!c.write || avmm_cmd.writedata == c.writedata))
                else report_error($sformatf("command %h, expected %h", avmm_cmd, c));
            end
            if (avmm_cmd.write)
            begin
                regs[avmm_cmd.address[5:0]] = avmm_cmd.writedata;
            end
            else
            begin
                rd_data_q.push_back(regs[avmm_cmd.address[5:0]]);
                rd_due_q.push_back(cyc + 1 + ({$random(seed)} % 4));
            end
        end
        // In-order read return after 1 to 4 cycles
        if (rd_due_q.size() != 0 && cyc >= rd_due_q[0])
        begin
            avmm_readdatavalid <= 1'b1;
            avmm_readdata      <= rd_data_q.pop_front();
            void'(rd_due_q.pop_front());
        end
    end

    // ====================
    // Response monitors
    // ====================

    always @(posedge clk)
    begin
        host_chan_pkg::t_mmio_rsp   r;
        host_chan_pkg::t_mem_rd_rsp m;
        int due;
        if (!rst && mmio_rsp.valid)
        begin
            assert (exp_rsp.size() != 0)
            else report_error("MMIO response with none expected");
            if (exp_rsp.size() != 0)
            begin
                r = exp_rsp.pop_front();
                assert (mmio_rsp.tid == r.tid && mmio_rsp.data == r.data)
                else report_error($sformatf("mmio rsp tid %h data %h, expected %h %h",
                                            mmio_rsp.tid, mmio_rsp.data, r.tid, r.data));
            end
        end
        if (!rst && mem_rd_rsp.valid)
        begin
            assert (exp_mem.size() != 0)
            else report_error("memory response with none expected");
            if (exp_mem.size() != 0)
            begin
                m   = exp_mem.pop_front();
                due = exp_cyc.pop_front();
                assert (mem_rd_rsp.tag == m.tag && mem_rd_rsp.data == m.data && cyc == due)
                else report_error($sformatf(
                    "mem rsp tag %h data %h cycle %0d, expected %h %h %0d",
                    mem_rd_rsp.tag, mem_rd_rsp.data, cyc, m.tag, m.data, due));
            end
        end
        // Accelerator reads go out to the host as they are
        if (!rst)
        begin
            assert (host_tx_mem == mem_rd_req)
            else report_error($sformatf("host_tx_mem %h, expected %h",
                                        host_tx_mem, mem_rd_req));
        end
    end

    // Ends a hung run
    initial
    begin
        repeat (TEST_BEATS * 20 + 50) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", TEST_BEATS * 20 + 50);
        $display("=== FAIL ===");
        $finish;
    end

    // ====================
    // Test sequence
    // ====================

    initial
    begin
        int e0;
        int sent0;
        int acc0;
        int issued;
        host_chan_pkg::t_host_rx b;
        seed = 32'hf1d8;
        errors = 0;
        cyc = 0;
        wait_pct = 20;
        mmio_sent = 0;
        cmd_accepted = 0;
        reads_issued = 0;
        model_lat = 0;
        host_rx = '0;
        mem_rd_req = '0;
        avmm_waitrequest = 1'b0;
        avmm_readdatavalid = 1'b0;
        avmm_readdata = '0;
        // Fill pattern over the whole word index
        for (int i = 0; i < 64; i++)
        begin
            regs[i]   = {32'(i) ^ 32'h5a5a0000, 32'(i) * 32'h9e3779b9};
            shadow[i] = regs[i];
        end
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        e0 = errors;
        repeat (40) send_beat(host_chan_pkg::RX_MMIO_WR);
        drain();
        finish_test("mmio_write", e0);

        e0 = errors;
        repeat (40) send_beat(host_chan_pkg::RX_MMIO_RD);
        drain();
        finish_test("mmio_read", e0);

        e0 = errors;
        repeat (60) send_beat(host_chan_pkg::t_rx_op'(1 + ({$random(seed)} % 3)));
        drain();
        finish_test("mem_bypass", e0);

        e0 = errors;
        sent0 = mmio_sent;
        acc0 = cmd_accepted;
        wait_pct = 80;
        repeat (80) send_beat(host_chan_pkg::t_rx_op'(1 + ({$random(seed)} % 2)));
        drain();
        assert (mmio_sent - sent0 == cmd_accepted - acc0)
        else report_error($sformatf("%0d commands for %0d requests",
                                    cmd_accepted - acc0, mmio_sent - sent0));
        finish_test("waitrequest", e0);

        e0 = errors;
        wait_pct = 20;
        issued = 0;
        while (issued < 30 || pend_tags.size() != 0)
        begin
            @(posedge clk);
            mem_rd_req.valid <= 1'b0;
            host_rx.op       <= host_chan_pkg::RX_NONE;
            if (issued < 30 && ({$random(seed)} % 2) == 0)
            begin
                mem_rd_req.valid <= 1'b1;
                mem_rd_req.tag   <= 8'(issued);
                mem_rd_req.addr  <= {$random(seed), $random(seed)};
                pend_tags.push_back(8'(issued));
                pend_cyc.push_back(cyc);
                issued++;
                reads_issued++;
            end
            if (pend_tags.size() != 0 && ({$random(seed)} % 3) == 0)
            begin
                b.op   = host_chan_pkg::RX_MEM_RD_RSP;
                b.tid  = {1'b0, pend_tags.pop_front()};
                b.addr = '0;
                b.data = {$random(seed), $random(seed)};
                push_mem_expect(b);
                // Completion reaches the accelerator one cycle after this beat
                model_lat += cyc + 1 - pend_cyc.pop_front();
                host_rx <= b;
            end
        end
        drain();
        assert (num_reads == 32'(reads_issued) && num_outstanding == '0 &&
                latency_sum == 32'(model_lat))
        else report_error($sformatf("counters %0d %0d %0d, expected %0d 0 %0d",
                                    num_reads, num_outstanding, latency_sum,
                                    reads_issued, model_lat));
        finish_test("events", e0);

        $display("tests run 5, checks failed %0d", errors);
        if (errors == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: flist.f
host_chan_pkg.sv
host_chan_rx_split.sv
mmio_req_fifo.sv
mmio_to_avalon.sv
host_chan_events.sv
host_chan_shim.sv
host_chan_checker.sv
tb_host_chan_shim.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP       ?= tb_host_chan_shim
FLIST     ?= flist.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)
